//--- design/l1_pkg.sv
package l1_pkg;

    // ------------------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int LINE_COUNT  = 64;
    localparam int INDEX_W     = 6;             // addr[7:2]
    localparam int TAG_W       = 24;            // addr[31:8]
    localparam int STRB_W      = 4;
    localparam int FIFO_DEPTH  = 4;             // power of two, pointers wrap
    localparam int MEM_WORDS   = 256;           // addr[9:2], aliases above
    localparam int MEM_LATENCY = 2;

    // derived widths
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int BUSY_W     = $clog2(MEM_LATENCY + 1);

    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL_CNT = FIFO_CNT_W'(FIFO_DEPTH);
    localparam logic [BUSY_W-1:0]     BUSY_LAST     = BUSY_W'(MEM_LATENCY - 1);

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        WT_WORD = 2'd0,
        WT_HALF = 2'd1,
        WT_BYTE = 2'd2
    } write_type_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic {
        ST_LOOKUP    = 1'b0,
        ST_MISS_WAIT = 1'b1
    } cache_state_e;

    typedef enum logic {
        RSP_IDLE = 1'b0,
        RSP_BUSY = 1'b1
    } resp_state_e;

endpackage

//--- design/l1_cache.sv
`timescale 1ns/10ps

module l1_cache (
    input  logic                       sys_clk,
    input  logic                       arst_n,
    // cpu side
    input  logic                       l1_read,
    input  logic                       l1_write,
    input  logic [l1_pkg::ADDR_W-1:0]  l1_addr,
    input  l1_pkg::write_type_e        l1_write_type,
    input  logic [l1_pkg::DATA_W-1:0]  l1_write_data,
    output logic [l1_pkg::DATA_W-1:0]  l1_data_o,
    output logic                       stall,
    // request buffer side
    output logic                       req_valid,
    input  logic                       req_ready,
    output l1_pkg::mem_op_e            req_op,
    output logic [l1_pkg::ADDR_W-1:0]  req_addr,
    output logic [l1_pkg::DATA_W-1:0]  req_wdata,
    output logic [l1_pkg::STRB_W-1:0]  req_strb,
    // fill return
    input  logic                       fill_done,
    input  logic [l1_pkg::DATA_W-1:0]  fill_data
);

    logic [l1_pkg::LINE_COUNT-1:0] valid_q;
    logic [l1_pkg::TAG_W-1:0]      tag_q  [l1_pkg::LINE_COUNT];
    logic [l1_pkg::DATA_W-1:0]     data_q [l1_pkg::LINE_COUNT];

    l1_pkg::cache_state_e state_q;
    l1_pkg::cache_state_e state_d;

    logic [l1_pkg::INDEX_W-1:0] index;
    logic [l1_pkg::TAG_W-1:0]   tag;
    logic [l1_pkg::INDEX_W-1:0] miss_index_q;
    logic [l1_pkg::TAG_W-1:0]   miss_tag_q;
    logic                       hit;

    logic [l1_pkg::STRB_W-1:0] strb;
    logic [l1_pkg::DATA_W-1:0] lane_data;
    logic [l1_pkg::DATA_W-1:0] merged;

    logic push;
    logic write_hit;
    logic fill_we;

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------
    assign index = l1_addr[l1_pkg::INDEX_W+1:2];
    assign tag   = l1_addr[l1_pkg::ADDR_W-1:l1_pkg::INDEX_W+2];
    assign hit   = valid_q[index] && (tag_q[index] == tag);

    assign l1_data_o = data_q[index];   // valid only when hit

    // ------------------------------------------------------------------------
    // byte strobes and lane data
    // ------------------------------------------------------------------------
    always_comb begin
        strb      = '0;
        lane_data = l1_write_data;
        case (l1_write_type)
            l1_pkg::WT_WORD: begin
                strb      = 4'b1111;
                lane_data = l1_write_data;
            end
            l1_pkg::WT_HALF: begin
                strb      = l1_addr[1] ? 4'b1100 : 4'b0011;  // bit 0 ignored
                lane_data = {2{l1_write_data[15:0]}};
            end
            l1_pkg::WT_BYTE: begin
                strb[l1_addr[1:0]] = 1'b1;
                lane_data          = {4{l1_write_data[7:0]}};
            end
            default: begin
                strb      = 4'b1111;   // unused code, treat as word
                lane_data = l1_write_data;
            end
        endcase
    end

    always_comb begin
        merged = data_q[index];
        for (int b = 0; b < l1_pkg::STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = lane_data[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // miss FSM and request side
    // ------------------------------------------------------------------------
    always_comb begin
        state_d   = state_q;
        req_valid = 1'b0;
        req_op    = l1_pkg::OP_READ;
        stall     = 1'b0;
        case (state_q)
            l1_pkg::ST_LOOKUP: begin
                if (l1_write) begin
                    req_valid = 1'b1;
                    req_op    = l1_pkg::OP_WRITE;
                    stall     = !req_ready;     // only when buffer full
                end else if (l1_read && !hit) begin
                    req_valid = 1'b1;
                    stall     = 1'b1;
                    if (req_ready) begin
                        state_d = l1_pkg::ST_MISS_WAIT;
                    end
                end
            end
            l1_pkg::ST_MISS_WAIT: begin
                stall = 1'b1;
                if (fill_done) begin
                    state_d = l1_pkg::ST_LOOKUP;
                end
            end
            default: begin
                state_d = l1_pkg::ST_LOOKUP;
            end
        endcase
    end

    assign req_addr  = {l1_addr[l1_pkg::ADDR_W-1:2], 2'b00};
    assign req_wdata = lane_data;
    assign req_strb  = l1_write ? strb : '0;

    assign push      = req_valid && req_ready;
    assign write_hit = push && (req_op == l1_pkg::OP_WRITE) && hit;
    assign fill_we   = (state_q == l1_pkg::ST_MISS_WAIT) && fill_done;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= l1_pkg::ST_LOOKUP;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_we) begin
                valid_q[miss_index_q] <= 1'b1;
            end
        end
    end

    // arrays and miss address
    always_ff @(posedge sys_clk) begin
        if (fill_we) begin
            tag_q[miss_index_q]  <= miss_tag_q;
            data_q[miss_index_q] <= fill_data;
        end
        if (write_hit) begin
            data_q[index] <= merged;    // write-through, no allocate on miss
        end
        if (push && (req_op == l1_pkg::OP_READ)) begin
            miss_index_q <= index;
            miss_tag_q   <= tag;
        end
    end

endmodule

//--- design/mem_req_fifo.sv
`timescale 1ns/10ps

module mem_req_fifo (
    input  logic                       sys_clk,
    input  logic                       arst_n,
    // push side
    input  logic                       req_valid,
    output logic                       req_ready,
    input  l1_pkg::mem_op_e            req_op,
    input  logic [l1_pkg::ADDR_W-1:0]  req_addr,
    input  logic [l1_pkg::DATA_W-1:0]  req_wdata,
    input  logic [l1_pkg::STRB_W-1:0]  req_strb,
    // pop side
    output logic                       out_valid,
    input  logic                       out_ready,
    output l1_pkg::mem_op_e            out_op,
    output logic [l1_pkg::ADDR_W-1:0]  out_addr,
    output logic [l1_pkg::DATA_W-1:0]  out_wdata,
    output logic [l1_pkg::STRB_W-1:0]  out_strb
);

    l1_pkg::mem_op_e            op_mem    [l1_pkg::FIFO_DEPTH];
    logic [l1_pkg::ADDR_W-1:0]  addr_mem  [l1_pkg::FIFO_DEPTH];
    logic [l1_pkg::DATA_W-1:0]  wdata_mem [l1_pkg::FIFO_DEPTH];
    logic [l1_pkg::STRB_W-1:0]  strb_mem  [l1_pkg::FIFO_DEPTH];

    logic [l1_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [l1_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [l1_pkg::FIFO_CNT_W-1:0] count_q;

    logic full;
    logic push;
    logic pop;

    assign full      = (count_q == l1_pkg::FIFO_FULL_CNT);
    assign req_ready = !full;
    assign out_valid = (count_q != '0);

    assign push = req_valid && req_ready;
    assign pop  = out_valid && out_ready;

    assign out_op    = op_mem[rd_ptr_q];
    assign out_addr  = addr_mem[rd_ptr_q];
    assign out_wdata = wdata_mem[rd_ptr_q];
    assign out_strb  = strb_mem[rd_ptr_q];

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // natural wrap
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push) begin
            op_mem[wr_ptr_q]    <= req_op;
            addr_mem[wr_ptr_q]  <= req_addr;
            wdata_mem[wr_ptr_q] <= req_wdata;
            strb_mem[wr_ptr_q]  <= req_strb;
        end
    end

endmodule

//--- design/mem_responder.sv
`timescale 1ns/10ps

module mem_responder (
    input  logic                       sys_clk,
    input  logic                       arst_n,
    // request buffer side
    input  logic                       out_valid,
    output logic                       out_ready,
    input  l1_pkg::mem_op_e            out_op,
    input  logic [l1_pkg::ADDR_W-1:0]  out_addr,
    input  logic [l1_pkg::DATA_W-1:0]  out_wdata,
    input  logic [l1_pkg::STRB_W-1:0]  out_strb,
    // fill return
    output logic                       fill_done,
    output logic [l1_pkg::DATA_W-1:0]  fill_data
);

    l1_pkg::resp_state_e       state_q;
    logic [l1_pkg::BUSY_W-1:0] busy_cnt_q;

    // request held during the busy time
    l1_pkg::mem_op_e           op_q;
    logic [l1_pkg::ADDR_W-1:0] addr_q;
    logic [l1_pkg::DATA_W-1:0] wdata_q;
    logic [l1_pkg::STRB_W-1:0] strb_q;

    logic [l1_pkg::DATA_W-1:0]    store_q [l1_pkg::MEM_WORDS];
    logic [l1_pkg::MEM_WORDS-1:0] written_q;

    logic [l1_pkg::MEM_IDX_W-1:0] mem_idx;
    logic [l1_pkg::DATA_W-1:0]    pattern;
    logic [l1_pkg::DATA_W-1:0]    cur_word;
    logic [l1_pkg::DATA_W-1:0]    merged;
    logic                         pop;
    logic                         finish;

    assign out_ready = (state_q == l1_pkg::RSP_IDLE);
    assign pop       = out_valid && out_ready;
    assign finish    = (state_q == l1_pkg::RSP_BUSY) && (busy_cnt_q == l1_pkg::BUSY_LAST);

    assign mem_idx  = addr_q[l1_pkg::MEM_IDX_W+1:2];
    assign pattern  = {addr_q[l1_pkg::ADDR_W-1:2], 2'b00} + 1'b1;  // never-written word
    assign cur_word = written_q[mem_idx] ? store_q[mem_idx] : pattern;

    always_comb begin
        merged = cur_word;
        for (int b = 0; b < l1_pkg::STRB_W; b++) begin
            if (strb_q[b]) begin
                merged[b*8 +: 8] = wdata_q[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= l1_pkg::RSP_IDLE;
            busy_cnt_q <= '0;
            fill_done  <= 1'b0;
            written_q  <= '0;
        end else begin
            fill_done <= 1'b0;
            case (state_q)
                l1_pkg::RSP_IDLE: begin
                    if (pop) begin
                        state_q    <= l1_pkg::RSP_BUSY;
                        busy_cnt_q <= '0;
                    end
                end
                l1_pkg::RSP_BUSY: begin
                    if (finish) begin
                        state_q <= l1_pkg::RSP_IDLE;
                        if (op_q == l1_pkg::OP_READ) begin
                            fill_done <= 1'b1;      // one-cycle pulse
                        end else begin
                            written_q[mem_idx] <= 1'b1;
                        end
                    end else begin
                        busy_cnt_q <= busy_cnt_q + 1'b1;
                    end
                end
                default: state_q <= l1_pkg::RSP_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pop) begin
            op_q    <= out_op;
            addr_q  <= out_addr;
            wdata_q <= out_wdata;
            strb_q  <= out_strb;
        end
        if (finish && (op_q == l1_pkg::OP_WRITE)) begin
            store_q[mem_idx] <= merged;
        end
        if (finish && (op_q == l1_pkg::OP_READ)) begin
            fill_data <= cur_word;
        end
    end

endmodule

//--- design/l1_subsystem.sv
`timescale 1ns/10ps

module l1_subsystem (
    input  logic                       sys_clk,
    input  logic                       arst_n,
    input  logic                       l1_read,
    input  logic                       l1_write,
    input  logic [l1_pkg::ADDR_W-1:0]  l1_addr,
    input  l1_pkg::write_type_e        l1_write_type,
    input  logic [l1_pkg::DATA_W-1:0]  l1_write_data,
    output logic [l1_pkg::DATA_W-1:0]  l1_data_o,
    output logic                       stall
);

    // ------------------------------------------------------------------------
    // cache to request buffer
    // ------------------------------------------------------------------------
    logic                      req_valid;
    logic                      req_ready;
    l1_pkg::mem_op_e           req_op;
    logic [l1_pkg::ADDR_W-1:0] req_addr;
    logic [l1_pkg::DATA_W-1:0] req_wdata;
    logic [l1_pkg::STRB_W-1:0] req_strb;

    // request buffer to memory
    logic                      out_valid;
    logic                      out_ready;
    l1_pkg::mem_op_e           out_op;
    logic [l1_pkg::ADDR_W-1:0] out_addr;
    logic [l1_pkg::DATA_W-1:0] out_wdata;
    logic [l1_pkg::STRB_W-1:0] out_strb;

    // fill return
    logic                      fill_done;
    logic [l1_pkg::DATA_W-1:0] fill_data;

    l1_cache u_cache (
        .sys_clk       (sys_clk),
        .arst_n        (arst_n),
        .l1_read       (l1_read),
        .l1_write      (l1_write),
        .l1_addr       (l1_addr),
        .l1_write_type (l1_write_type),
        .l1_write_data (l1_write_data),
        .l1_data_o     (l1_data_o),
        .stall         (stall),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strb      (req_strb),
        .fill_done     (fill_done),
        .fill_data     (fill_data)
    );

    mem_req_fifo u_fifo (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_strb  (req_strb),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_op    (out_op),
        .out_addr  (out_addr),
        .out_wdata (out_wdata),
        .out_strb  (out_strb)
    );

    mem_responder u_mem (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_op    (out_op),
        .out_addr  (out_addr),
        .out_wdata (out_wdata),
        .out_strb  (out_strb),
        .fill_done (fill_done),
        .fill_data (fill_data)
    );

endmodule

//--- tb/l1_props.sv
`timescale 1ns/10ps

module l1_props (
    input  logic                                                sys_clk,
    input  logic                                                arst_n,
    input  logic                                                stall,
    input  logic                                                fill_done,
    input  logic                                                miss_wait,
    input  logic                                                req_valid,
    input  logic                                                req_ready,
    input  logic [l1_pkg::ADDR_W+l1_pkg::DATA_W+l1_pkg::STRB_W:0] req_word,
    input  logic [l1_pkg::FIFO_PTR_W-1:0]                       wr_ptr,
    input  logic                                                full
);

    stall_low_after_reset: assert property (@(posedge sys_clk) $rose(arst_n) |-> !stall)
        else $error("stall high in the first cycle after reset");

    fill_only_in_miss_wait: assert property (@(posedge sys_clk) disable iff (!arst_n)
        fill_done |-> miss_wait)
        else $error("fill_done outside ST_MISS_WAIT");

    // request held until the buffer takes it
    req_held_until_accepted: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_word)))
        else $error("request dropped or changed before acceptance");

    // no slot written while full
    no_push_when_full: assert property (@(posedge sys_clk) disable iff (!arst_n)
        full |=> $stable(wr_ptr))
        else $error("request buffer pushed while full");

endmodule

bind l1_cache l1_props u_cache_props (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .fill_done (fill_done),
    .miss_wait (state_q == l1_pkg::ST_MISS_WAIT),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_word  ({req_op, req_addr, req_wdata, req_strb}),
    .wr_ptr    ('0),                // buffer side checked in the fifo bind
    .full      (1'b0)
);

bind mem_req_fifo l1_props u_fifo_props (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .stall     (1'b0),
    .fill_done (1'b0),
    .miss_wait (1'b0),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_word  ({req_op, req_addr, req_wdata, req_strb}),
    .wr_ptr    (wr_ptr_q),
    .full      (full)
);

//--- tb/tb_l1_subsystem.sv
`timescale 1ns/10ps

module tb_l1_subsystem;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RAND_OPS       = 40;
    localparam bit RD             = 1'b0;
    localparam bit WR             = 1'b1;

    typedef struct packed {
        bit          is_wr;
        logic [1:0]  wt;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;             // reads only
    } entry_t;

    logic                      sys_clk;
    logic                      arst_n;
    logic                      l1_read;
    logic                      l1_write;
    logic [l1_pkg::ADDR_W-1:0] l1_addr;
    l1_pkg::write_type_e       l1_write_type;
    logic [l1_pkg::DATA_W-1:0] l1_write_data;
    logic [l1_pkg::DATA_W-1:0] l1_data_o;
    logic                      stall;

    // reference memory and cache presence
    logic [31:0] ref_mem     [l1_pkg::MEM_WORDS];
    bit          ref_written [l1_pkg::MEM_WORDS];
    bit          ref_cvalid  [l1_pkg::LINE_COUNT];
    logic [23:0] ref_ctag    [l1_pkg::LINE_COUNT];

    entry_t table_q [$];
    string  name_q  [$];
    int     pass_cnt;
    int     fail_cnt;
    int     seed;
    bit     timed_out;
    bit     write_stalled;

    l1_subsystem u_dut (
        .sys_clk       (sys_clk),
        .arst_n        (arst_n),
        .l1_read       (l1_read),
        .l1_write      (l1_write),
        .l1_addr       (l1_addr),
        .l1_write_type (l1_write_type),
        .l1_write_data (l1_write_data),
        .l1_data_o     (l1_data_o),
        .stall         (stall)
    );

    always #2 sys_clk = ~sys_clk;

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        int i;
        i = int'(addr[9:2]);
        if (ref_written[i]) begin
            return ref_mem[i];
        end
        return {addr[31:2], 2'b00} + 32'd1;     // never written
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [1:0] wt,
                                        input logic [31:0] wdata);
        logic [31:0] word;
        int          i;
        word = mem_word(addr);
        i    = int'(addr[9:2]);
        case (wt)
            l1_pkg::WT_HALF: begin
                if (addr[1]) begin
                    word[31:16] = wdata[15:0];
                end else begin
                    word[15:0] = wdata[15:0];
                end
            end
            l1_pkg::WT_BYTE: word[addr[1:0]*8 +: 8] = wdata[7:0];
            default:         word = wdata;
        endcase
        ref_mem[i]     = word;
        ref_written[i] = 1'b1;
    endfunction

    function automatic bit model_hit(input logic [31:0] addr);
        return ref_cvalid[addr[7:2]] && (ref_ctag[addr[7:2]] == addr[31:8]);
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic add_entry(input string name, input bit is_wr, input logic [1:0] wt,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [31:0] exp);
        entry_t e;
        e.is_wr = is_wr;
        e.wt    = wt;
        e.addr  = addr;
        e.wdata = wdata;
        e.exp   = exp;
        table_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        add_entry("rd_pattern",    RD, 2'd0, 32'h40,  32'h0,        32'h0000_0041);
        add_entry("rd_repeat_hit", RD, 2'd0, 32'h40,  32'h0,        32'h0000_0041);
        add_entry("wr_word_hit",   WR, 2'd0, 32'h40,  32'hDEAD_BEEF, 32'h0);
        add_entry("rd_word",       RD, 2'd0, 32'h40,  32'h0,        32'hDEAD_BEEF);
        add_entry("wr_half_lo",    WR, 2'd1, 32'h40,  32'h9999_1234, 32'h0);
        add_entry("rd_half_lo",    RD, 2'd0, 32'h40,  32'h0,        32'hDEAD_1234);
        add_entry("wr_half_hi",    WR, 2'd1, 32'h42,  32'h8888_ABCD, 32'h0);
        add_entry("rd_half_hi",    RD, 2'd0, 32'h40,  32'h0,        32'hABCD_1234);
        add_entry("wr_byte0",      WR, 2'd2, 32'h40,  32'hEEEE_EE11, 32'h0);
        add_entry("wr_byte1",      WR, 2'd2, 32'h41,  32'hEEEE_EE22, 32'h0);
        add_entry("rd_byte01",     RD, 2'd0, 32'h40,  32'h0,        32'hABCD_2211);
        add_entry("wr_byte2",      WR, 2'd2, 32'h42,  32'hEEEE_EE33, 32'h0);
        add_entry("wr_byte3",      WR, 2'd2, 32'h43,  32'hEEEE_EE44, 32'h0);
        add_entry("rd_byte23",     RD, 2'd0, 32'h40,  32'h0,        32'h4433_2211);
        add_entry("wr_half_odd",   WR, 2'd1, 32'h43,  32'h7777_5566, 32'h0);
        add_entry("rd_half_odd",   RD, 2'd0, 32'h40,  32'h0,        32'h5566_2211);
        add_entry("wr_miss_byte",  WR, 2'd2, 32'h81,  32'h0000_0077, 32'h0);
        add_entry("rd_after_miss", RD, 2'd0, 32'h80,  32'h0,        32'h0000_7781);
        add_entry("rd_evict_a",    RD, 2'd0, 32'h140, 32'h0,        32'h0000_0141);
        add_entry("rd_evict_b",    RD, 2'd0, 32'h40,  32'h0,        32'h5566_2211);
        add_entry("rd_evict_a2",   RD, 2'd0, 32'h140, 32'h0,        32'h0000_0141);
        for (int i = 0; i < 8; i++) begin
            add_entry($sformatf("fifo_wr%0d", i), WR, 2'd0, 32'h200 + 32'(4 * i),
                      32'hCAFE_0000 + 32'(i), 32'h0);
        end
        add_entry("rd_fifo_first", RD, 2'd0, 32'h200, 32'h0,        32'hCAFE_0000);
        add_entry("rd_fifo_mid",   RD, 2'd0, 32'h210, 32'h0,        32'hCAFE_0004);
        add_entry("rd_fifo_last",  RD, 2'd0, 32'h21C, 32'h0,        32'hCAFE_0007);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic access(input bit is_wr, input logic [1:0] wt, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int stalls);
        l1_read       = !is_wr;
        l1_write      = is_wr;
        l1_addr       = addr;
        l1_write_type = l1_pkg::write_type_e'(wt);
        l1_write_data = wdata;
        stalls        = 0;
        rdata         = '0;
        #2;
        while (stall && stalls < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            #3;
            stalls++;
        end
        if (stall) begin
            $display("timeout: stall stayed high for %0d cycles at address %08h",
                     stalls, addr);
            timed_out = 1'b1;
            fail_cnt++;
        end else begin
            rdata = l1_data_o;
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic run_check(input string name, input bit is_wr, input logic [1:0] wt,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [31:0] exp);
        logic [31:0] got;
        int          stalls;
        bit          hit;
        bit          ok;
        hit = model_hit(addr);
        ok  = 1'b1;
        access(is_wr, wt, addr, wdata, got, stalls);
        if (!timed_out) begin
            if (is_wr) begin
                model_write(addr, wt, wdata);
                if (stalls > 0) begin
                    write_stalled = 1'b1;
                end
            end else begin
                assert (got == exp) else begin
                    $display("ERROR %s expected %08h actual %08h", name, exp, got);
                    ok = 1'b0;
                end
                if (ok) begin
                    assert (hit ? (stalls == 0) : (stalls > 0)) else begin
                        $display("%s: read %s but stalled for %0d cycles", name,
                                 hit ? "should hit" : "should miss", stalls);
                        ok = 1'b0;
                    end
                end
                ref_cvalid[addr[7:2]] = 1'b1;
                ref_ctag[addr[7:2]]   = addr[31:8];
            end
            if (ok) begin
                pass_cnt++;
                $display("ok    %s (%0d stall cycles)", name, stalls);
            end else begin
                fail_cnt++;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  wt;
        bit          is_wr;
        sys_clk       = 1'b0;
        arst_n        = 1'b0;
        l1_read       = 1'b0;
        l1_write      = 1'b0;
        l1_addr       = '0;
        l1_write_type = l1_pkg::WT_WORD;
        l1_write_data = '0;
        seed          = 17;
        build_table();

        repeat (3) @(posedge sys_clk);
        #1;
        arst_n = 1'b1;
        @(posedge sys_clk);
        #1;

        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            run_check(name_q[i], table_q[i].is_wr, table_q[i].wt, table_q[i].addr,
                      table_q[i].wdata, table_q[i].exp);
        end
        if (!timed_out) begin
            assert (write_stalled) begin
                pass_cnt++;
                $display("ok    fifo_full_stall");
            end else begin
                $display("fifo_full_stall: no write stalled during the write burst");
                fail_cnt++;
            end
        end

        // ------------------------------------------------------------------------
        // random phase, 16 addresses over 4 indexes
        // ------------------------------------------------------------------------
        for (int k = 0; k < RAND_OPS && !timed_out; k++) begin
            r     = $random(seed);
            wdata = $random(seed);
            is_wr = r[0];
            wt    = (r[11:10] == 2'd3) ? 2'd0 : r[11:10];
            addr  = {21'd0, 1'b1, r[5:4], 6'd12 + {1'b0, r[7:6], 3'b000}, 2'b00};
            if (is_wr) begin
                addr[1:0] = r[9:8];     // lane offset
            end
            run_check($sformatf("rand_%0d", k), is_wr, wt, addr, wdata, mem_word(addr));
        end
        l1_read  = 1'b0;
        l1_write = 1'b0;

        $display("summary: %0d passed, %0d failed%s", pass_cnt, fail_cnt,
                 timed_out ? ", stopped on timeout" : "");
        if (fail_cnt == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
design/l1_pkg.sv
design/l1_cache.sv
design/mem_req_fifo.sv
design/mem_responder.sv
design/l1_subsystem.sv
tb/l1_props.sv
tb/tb_l1_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the l1 subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_l1_subsystem \
    -f flist.f \
    -o sim_l1

./obj_dir/sim_l1 > sim.log 2>&1
cat sim.log

if grep -qx "test failed" sim.log; then
    exit 1
fi
exit 0
